// ==== addr_router.sv ====
// ------------------------------------------------
// Address router
// Decodes the request address, steers it to one
// target and returns responses in request order.
// Unmapped addresses get an error response
// ------------------------------------------------
`include "soc_config.svh"

module addr_router (
  input  logic      clk_i,
  input  logic      reset_i,
  soc_bus_if.sub    mgr_bus,
  soc_bus_if.mgr    sram_bus,
  soc_bus_if.mgr    ctrl_bus,
  soc_bus_if.mgr    gpio_bus,
  soc_bus_if.mgr    timer_bus
);
  import soc_pkg::*;

  target_e tgt_d;
  target_e tgt_q;
  logic    err_valid_q;

  // Unsigned offset compare also rejects addresses below base
  function automatic logic in_window(addr_t addr, addr_t base, addr_t size);
    return (addr - base) < size;
  endfunction

  // ------------------------------------------------
  // Address decode
  // ------------------------------------------------
  always_comb begin
    if (in_window(mgr_bus.addr, `SOC_SRAM_BASE, `SOC_SRAM_WORDS * 4)) begin
      tgt_d = TGT_SRAM;
    end else if (in_window(mgr_bus.addr, `SOC_CTRL_BASE, `SOC_PERIPH_SIZE)) begin
      tgt_d = TGT_CTRL;
    end else if (in_window(mgr_bus.addr, `SOC_GPIO_BASE, `SOC_PERIPH_SIZE)) begin
      tgt_d = TGT_GPIO;
    end else if (in_window(mgr_bus.addr, `SOC_TIMER_BASE, `SOC_PERIPH_SIZE)) begin
      tgt_d = TGT_TIMER;
    end else begin
      tgt_d = TGT_ERR;
    end
  end

  // Request strobe to the selected target only
  assign sram_bus.req  = mgr_bus.req && (tgt_d == TGT_SRAM);
  assign ctrl_bus.req  = mgr_bus.req && (tgt_d == TGT_CTRL);
  assign gpio_bus.req  = mgr_bus.req && (tgt_d == TGT_GPIO);
  assign timer_bus.req = mgr_bus.req && (tgt_d == TGT_TIMER);

  // Payload is shared by all targets
  assign sram_bus.addr   = mgr_bus.addr;
  assign sram_bus.we     = mgr_bus.we;
  assign sram_bus.be     = mgr_bus.be;
  assign sram_bus.wdata  = mgr_bus.wdata;
  assign ctrl_bus.addr   = mgr_bus.addr;
  assign ctrl_bus.we     = mgr_bus.we;
  assign ctrl_bus.be     = mgr_bus.be;
  assign ctrl_bus.wdata  = mgr_bus.wdata;
  assign gpio_bus.addr   = mgr_bus.addr;
  assign gpio_bus.we     = mgr_bus.we;
  assign gpio_bus.be     = mgr_bus.be;
  assign gpio_bus.wdata  = mgr_bus.wdata;
  assign timer_bus.addr  = mgr_bus.addr;
  assign timer_bus.we    = mgr_bus.we;
  assign timer_bus.be    = mgr_bus.be;
  assign timer_bus.wdata = mgr_bus.wdata;

  // ------------------------------------------------
  // Response steering
  // ------------------------------------------------
  // Target of the request in flight, plus the error slot
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tgt_q       <= TGT_SRAM;
      err_valid_q <= 1'b0;
    end else begin
      if (mgr_bus.req) begin
        tgt_q <= tgt_d;
      end
      err_valid_q <= mgr_bus.req && (tgt_d == TGT_ERR);
    end
  end

  always_comb begin
    case (tgt_q)
      TGT_SRAM: begin
        mgr_bus.rvalid = sram_bus.rvalid;
        mgr_bus.rdata  = sram_bus.rdata;
        mgr_bus.err    = sram_bus.err;
      end
      TGT_CTRL: begin
        mgr_bus.rvalid = ctrl_bus.rvalid;
        mgr_bus.rdata  = ctrl_bus.rdata;
        mgr_bus.err    = ctrl_bus.err;
      end
      TGT_GPIO: begin
        mgr_bus.rvalid = gpio_bus.rvalid;
        mgr_bus.rdata  = gpio_bus.rdata;
        mgr_bus.err    = gpio_bus.err;
      end
      TGT_TIMER: begin
        mgr_bus.rvalid = timer_bus.rvalid;
        mgr_bus.rdata  = timer_bus.rdata;
        mgr_bus.err    = timer_bus.err;
      end
      default: begin
        mgr_bus.rvalid = err_valid_q;
        mgr_bus.rdata  = `SOC_ERR_DATA;
        mgr_bus.err    = 1'b1;
      end
    endcase
  end

endmodule

// ==== gpio_unit.sv ====
// ------------------------------------------------
// GPIO block
// Two-flop input sync, direction and output
// registers, rising-edge interrupts
// ------------------------------------------------
`include "soc_config.svh"

module gpio_unit (
  input  logic               clk_i,
  input  logic               reset_i,
  soc_bus_if.sub             bus,
  input  soc_pkg::gpio_vec_t gpio_i,
  output soc_pkg::gpio_vec_t gpio_o,
  output soc_pkg::gpio_vec_t gpio_out_en_o,
  output soc_pkg::gpio_vec_t gpio_in_sync_o,
  output logic               irq_o
);
  import soc_pkg::*;

  localparam int unsigned OffW = $clog2(`SOC_PERIPH_SIZE);
  localparam logic [OffW-1:0] OFF_DIR  = 'h0;
  localparam logic [OffW-1:0] OFF_OUT  = 'h4;
  localparam logic [OffW-1:0] OFF_IN   = 'h8;
  localparam logic [OffW-1:0] OFF_IE   = 'hC;
  localparam logic [OffW-1:0] OFF_PEND = 'h10;

  logic [OffW-1:0] offset;
  logic            wr;
  gpio_vec_t       meta_q, sync_q, prev_q;
  gpio_vec_t       dir_q, out_q, ie_q, pend_q;
  gpio_vec_t       rise;
  gpio_vec_t       clr;
  word_t           rd_word;
  logic            rvalid_q;
  word_t           rdata_q;

  assign offset = bus.addr[OffW-1:0];
  assign wr     = bus.req && bus.we;

  // Rising edges and the write-one-to-clear mask
  assign rise = sync_q & ~prev_q;
  assign clr  = (wr && offset == OFF_PEND) ? gpio_vec_t'(bus.wdata) : '0;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      meta_q   <= '0;
      sync_q   <= '0;
      prev_q   <= '0;
      dir_q    <= '0;
      out_q    <= '0;
      ie_q     <= '0;
      pend_q   <= '0;
      rvalid_q <= 1'b0;
    end else begin
      meta_q <= gpio_i;
      sync_q <= meta_q;
      prev_q <= sync_q;
      if (wr && offset == OFF_DIR) dir_q <= gpio_vec_t'(bus.wdata);
      if (wr && offset == OFF_OUT) out_q <= gpio_vec_t'(bus.wdata);
      if (wr && offset == OFF_IE)  ie_q  <= gpio_vec_t'(bus.wdata);
      // New edge wins over a clear in the same cycle
      pend_q   <= (pend_q & ~clr) | (rise & ie_q);
      rvalid_q <= bus.req;
    end
  end

  // Register read mux
  always_comb begin
    case (offset)
      OFF_DIR:  rd_word = word_t'(dir_q);
      OFF_OUT:  rd_word = word_t'(out_q);
      OFF_IN:   rd_word = word_t'(sync_q);
      OFF_IE:   rd_word = word_t'(ie_q);
      OFF_PEND: rd_word = word_t'(pend_q);
      default:  rd_word = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (bus.req) rdata_q <= bus.we ? '0 : rd_word;
  end

  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;
  assign bus.err    = 1'b0;

  assign gpio_o         = out_q;
  assign gpio_out_en_o  = dir_q;
  assign gpio_in_sync_o = sync_q;
  assign irq_o          = |pend_q;

endmodule

// ==== project.f ====
+incdir+.
soc_pkg.sv
soc_bus_if.sv
addr_router.sv
sram_bank.sv
soc_ctrl_regs.sv
gpio_unit.sv
timer_unit.sv
soc_domain.sv
tb_clock_gen.sv
tb_soc_domain.sv

// ==== soc_bus_if.sv ====
// ------------------------------------------------
// Internal request/response bus
// Request accepted in the cycle req is high and
// answered with rvalid exactly one cycle later
// ------------------------------------------------
interface soc_bus_if;
  import soc_pkg::*;

  // Request channel
  logic  req;
  addr_t addr;
  logic  we;
  be_t   be;
  word_t wdata;

  // Response channel
  logic  rvalid;
  word_t rdata;
  logic  err;

  // Manager side drives the request
  modport mgr (
    output req, addr, we, be, wdata,
    input  rvalid, rdata, err
  );

  // Subordinate side answers it
  modport sub (
    input  req, addr, we, be, wdata,
    output rvalid, rdata, err
  );

endinterface

// ==== soc_config.svh ====
// ------------------------------------------------
// SoC domain configuration
// Address map, SRAM geometry, GPIO width and the
// read word returned for unmapped accesses
// ------------------------------------------------
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// Address map
`define SOC_SRAM_BASE   32'h1000_0000
`define SOC_CTRL_BASE   32'h0300_0000
`define SOC_GPIO_BASE   32'h0300_5000
`define SOC_TIMER_BASE  32'h0300_A000
`define SOC_PERIPH_SIZE 32'h0000_1000

// SRAM geometry in 32-bit words
`define SOC_SRAM_WORDS  256
`define SOC_SRAM_IDX_W  8

`define SOC_GPIO_COUNT  8

// Error response data
`define SOC_ERR_DATA    32'hBADCAB1E

`endif

// ==== soc_ctrl_regs.sv ====
// ------------------------------------------------
// SoC control registers
// Boot address and fetch enable registers
// Fetch enable is ORed with the external pin
// ------------------------------------------------
`include "soc_config.svh"

module soc_ctrl_regs (
  input  logic           clk_i,
  input  logic           reset_i,
  input  logic           fetch_en_i,
  soc_bus_if.sub         bus,
  output logic           fetch_enable_o,
  output soc_pkg::addr_t boot_addr_o
);
  import soc_pkg::*;

  localparam int unsigned OffW = $clog2(`SOC_PERIPH_SIZE);
  localparam logic [OffW-1:0] OFF_BOOT  = 'h0;
  localparam logic [OffW-1:0] OFF_FETCH = 'h4;

  logic [OffW-1:0] offset;
  logic            hit_boot;
  logic            hit_fetch;
  addr_t           boot_q;
  logic            fetch_q;
  logic            rvalid_q;
  logic            err_q;
  word_t           rdata_q;

  assign offset    = bus.addr[OffW-1:0];
  assign hit_boot  = (offset == OFF_BOOT);
  assign hit_fetch = (offset == OFF_FETCH);

  // Register state and response handshake
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      boot_q   <= `SOC_SRAM_BASE;
      fetch_q  <= 1'b0;
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      if (bus.req && bus.we && hit_boot) begin
        boot_q <= bus.wdata;
      end
      if (bus.req && bus.we && hit_fetch) begin
        fetch_q <= bus.wdata[0];
      end
      rvalid_q <= bus.req;
      err_q    <= bus.req && !(hit_boot || hit_fetch);
    end
  end

  // Error word for unknown offsets
  always_ff @(posedge clk_i) begin
    if (bus.req) begin
      if (!(hit_boot || hit_fetch)) begin
        rdata_q <= `SOC_ERR_DATA;
      end else if (bus.we) begin
        rdata_q <= '0;
      end else begin
        rdata_q <= hit_boot ? boot_q : word_t'(fetch_q);
      end
    end
  end

  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;
  assign bus.err    = err_q;

  assign fetch_enable_o = fetch_q | fetch_en_i;
  assign boot_addr_o    = boot_q;

endmodule

// ==== soc_domain.sv ====
// ------------------------------------------------
// SoC peripheral domain top level
// External bus manager port, router, SRAM bank,
// SoC control, GPIO and timer
// ------------------------------------------------
module soc_domain (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              fetch_en_i,

  input  logic              req_i,
  input  logic              we_i,
  input  soc_pkg::addr_t    addr_i,
  input  soc_pkg::be_t      be_i,
  input  soc_pkg::word_t    wdata_i,
  output logic              rvalid_o,
  output logic              err_o,
  output soc_pkg::word_t    rdata_o,

  input  soc_pkg::gpio_vec_t gpio_i,
  output soc_pkg::gpio_vec_t gpio_o,
  output soc_pkg::gpio_vec_t gpio_out_en_o,
  output soc_pkg::gpio_vec_t gpio_in_sync_o,

  // Bit 0 timer, bit 1 GPIO
  output logic [1:0]        irq_o,
  output logic              fetch_enable_o,
  output soc_pkg::addr_t    boot_addr_o
);
  import soc_pkg::*;

  logic timer_irq;
  logic gpio_irq;

  // ------------------------------------------------
  // Buses
  // ------------------------------------------------
  soc_bus_if mgr_bus ();
  soc_bus_if sram_bus ();
  soc_bus_if ctrl_bus ();
  soc_bus_if gpio_bus ();
  soc_bus_if timer_bus ();

  // External manager onto the internal bus
  assign mgr_bus.req   = req_i;
  assign mgr_bus.addr  = addr_i;
  assign mgr_bus.we    = we_i;
  assign mgr_bus.be    = be_i;
  assign mgr_bus.wdata = wdata_i;

  assign rvalid_o = mgr_bus.rvalid;
  assign rdata_o  = mgr_bus.rdata;
  assign err_o    = mgr_bus.err;

  assign irq_o = {gpio_irq, timer_irq};

  // ------------------------------------------------
  // Interconnect and targets
  // ------------------------------------------------
  addr_router i_router (
    .clk_i     ( clk_i     ),
    .reset_i   ( reset_i   ),
    .mgr_bus   ( mgr_bus   ),
    .sram_bus  ( sram_bus  ),
    .ctrl_bus  ( ctrl_bus  ),
    .gpio_bus  ( gpio_bus  ),
    .timer_bus ( timer_bus )
  );

  sram_bank i_sram (
    .clk_i   ( clk_i    ),
    .reset_i ( reset_i  ),
    .bus     ( sram_bus )
  );

  soc_ctrl_regs i_soc_ctrl (
    .clk_i          ( clk_i          ),
    .reset_i        ( reset_i        ),
    .fetch_en_i     ( fetch_en_i     ),
    .bus            ( ctrl_bus       ),
    .fetch_enable_o ( fetch_enable_o ),
    .boot_addr_o    ( boot_addr_o    )
  );

  gpio_unit i_gpio (
    .clk_i          ( clk_i          ),
    .reset_i        ( reset_i        ),
    .bus            ( gpio_bus       ),
    .gpio_i         ( gpio_i         ),
    .gpio_o         ( gpio_o         ),
    .gpio_out_en_o  ( gpio_out_en_o  ),
    .gpio_in_sync_o ( gpio_in_sync_o ),
    .irq_o          ( gpio_irq       )
  );

  timer_unit i_timer (
    .clk_i   ( clk_i     ),
    .reset_i ( reset_i   ),
    .bus     ( timer_bus ),
    .irq_o   ( timer_irq )
  );

endmodule

// ==== soc_pkg.sv ====
// ------------------------------------------------
// SoC domain types
// Bus word, address and byte-enable vectors, the
// SRAM index, GPIO vector and routing targets
// ------------------------------------------------
`include "soc_config.svh"

package soc_pkg;

  // Bus payload
  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [3:0]  be_t;

  // SRAM word index
  typedef logic [`SOC_SRAM_IDX_W-1:0] sram_idx_t;

  // One bit per GPIO pin
  typedef logic [`SOC_GPIO_COUNT-1:0] gpio_vec_t;

  // Router targets with TGT_ERR for unmapped requests
  typedef enum logic [2:0] {
    TGT_SRAM,
    TGT_CTRL,
    TGT_GPIO,
    TGT_TIMER,
    TGT_ERR
  } target_e;

endpackage

// ==== sram_bank.sv ====
// ------------------------------------------------
// SRAM bank
// Single-port word memory, byte-lane writes and
// one-cycle registered reads
// ------------------------------------------------
`include "soc_config.svh"

module sram_bank (
  input  logic   clk_i,
  input  logic   reset_i,
  soc_bus_if.sub bus
);
  import soc_pkg::*;

  word_t     mem [`SOC_SRAM_WORDS];
  sram_idx_t idx;
  logic      rvalid_q;
  word_t     rdata_q;

  // Word index from address bits above the byte offset
  assign idx = bus.addr[`SOC_SRAM_IDX_W+1:2];

  // Array write of the enabled lanes only
  always_ff @(posedge clk_i) begin
    if (bus.req && bus.we) begin
      for (int lane = 0; lane < 4; lane++) begin
        if (bus.be[lane]) begin
          mem[idx][lane*8 +: 8] <= bus.wdata[lane*8 +: 8];
        end
      end
    end
  end

  // Writes return zero read data
  always_ff @(posedge clk_i) begin
    if (bus.req) begin
      rdata_q <= bus.we ? '0 : mem[idx];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus.req;
    end
  end

  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;
  assign bus.err    = 1'b0;

endmodule

// ==== tb_clock_gen.sv ====
// ------------------------------------------------
// Testbench clock generator
// Free-running clock with 50 percent duty cycle
// ------------------------------------------------
module tb_clock_gen #(
  parameter int unsigned PERIOD_NS = 40
) (
  output logic clk_o
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

endmodule

// ==== tb_soc_domain.sv ====
// ------------------------------------------------
// SoC domain testbench
// Directed tests over the external bus port for
// reset state, SRAM, error responses, GPIO, timer
// ------------------------------------------------
`include "soc_config.svh"

module tb_soc_domain;
  timeunit 1ns;
  timeprecision 100ps;
  import soc_pkg::*;

  localparam int TIMEOUT = 20;
  localparam int SRAM_N  = 8;

  logic      clk, reset, fetch_en, req, we;
  addr_t     addr;
  be_t       be;
  word_t     wdata;
  gpio_vec_t gpio_in;
  logic      rvalid, err, fetch_enable;
  word_t     rdata;
  gpio_vec_t gpio_out, gpio_oe, gpio_sync;
  logic [1:0] irq;
  addr_t     boot_addr;

  integer seed;
  int     errors;
  int     checks;
  int     tests;

  tb_clock_gen #(.PERIOD_NS(40)) i_clk_gen (.clk_o(clk));

  soc_domain i_dut (
    .clk_i          ( clk          ),
    .reset_i        ( reset        ),
    .fetch_en_i     ( fetch_en     ),
    .req_i          ( req          ),
    .we_i           ( we           ),
    .addr_i         ( addr         ),
    .be_i           ( be           ),
    .wdata_i        ( wdata        ),
    .rvalid_o       ( rvalid       ),
    .err_o          ( err          ),
    .rdata_o        ( rdata        ),
    .gpio_i         ( gpio_in      ),
    .gpio_o         ( gpio_out     ),
    .gpio_out_en_o  ( gpio_oe      ),
    .gpio_in_sync_o ( gpio_sync    ),
    .irq_o          ( irq          ),
    .fetch_enable_o ( fetch_enable ),
    .boot_addr_o    ( boot_addr    )
  );

  // ------------------------------------------------
  // Helpers
  // ------------------------------------------------
  // Drive and sample point 2 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic check_value(input word_t got, input word_t exp, input string what);
    checks++;
    assert (got === exp) else begin
      $display("FAIL at %0d ns: %s, got %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  // Byte-lane merge of a write into a stored word
  function automatic word_t merge_bytes(word_t old_word, word_t new_word, be_t lanes);
    word_t result;
    result = old_word;
    for (int lane = 0; lane < 4; lane++) begin
      if (lanes[lane]) result[lane*8 +: 8] = new_word[lane*8 +: 8];
    end
    return result;
  endfunction

  // Single request and the wait for its response
  task automatic bus_access(input logic wr, input addr_t a, input be_t lanes,
                            input word_t wd, output word_t rd, output logic er);
    int waited;
    req   = 1'b1;
    we    = wr;
    addr  = a;
    be    = lanes;
    wdata = wd;
    next_cycle();
    req     = 1'b0;
    we      = 1'b0;
    waited  = 0;
    while (!rvalid && waited < TIMEOUT) begin
      next_cycle();
      waited++;
    end
    rd = rdata;
    er = err;
    if (!rvalid) begin
      $display("Timeout: no bus response for address %h within %0d cycles", a, TIMEOUT);
      errors++;
    end else begin
      check_value(waited, 0, "response latency beyond one cycle");
    end
  endtask

  task automatic wait_irq(input int line, output logic seen);
    int waited;
    waited = 0;
    while (!irq[line] && waited < TIMEOUT) begin
      next_cycle();
      waited++;
    end
    seen = irq[line];
    if (!seen) begin
      $display("Timeout: interrupt line %0d did not rise within %0d cycles", line, TIMEOUT);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests++;
    if (errors == errors_before) $display("Test %s passed", name);
    else $display("Test %s failed with %0d errors", name, errors - errors_before);
  endtask

  // ------------------------------------------------
  // Tests
  // ------------------------------------------------
  task automatic test_reset_state();
    int    start;
    word_t rd;
    logic  er;
    start = errors;
    check_value(rvalid, 0, "rvalid_o after reset");
    check_value(err, 0, "err_o after reset");
    check_value(irq, 0, "irq_o after reset");
    check_value(fetch_enable, 0, "fetch_enable_o after reset");
    check_value(gpio_out, 0, "gpio_o after reset");
    check_value(gpio_oe, 0, "gpio_out_en_o after reset");
    check_value(boot_addr, `SOC_SRAM_BASE, "boot_addr_o after reset");
    bus_access(1'b1, `SOC_CTRL_BASE, 4'hF, 32'h1000_0040, rd, er);
    check_value(boot_addr, 32'h1000_0040, "boot_addr_o after write");
    bus_access(1'b0, `SOC_CTRL_BASE, 4'hF, '0, rd, er);
    check_value(rd, 32'h1000_0040, "boot address readback");
    check_value(er, 0, "err_o on boot address read");
    // Pin only with the register still clear
    fetch_en = 1'b1;
    next_cycle();
    check_value(fetch_enable, 1, "fetch_enable_o with pin high");
    fetch_en = 1'b0;
    next_cycle();
    check_value(fetch_enable, 0, "fetch_enable_o with pin low");
    bus_access(1'b1, `SOC_CTRL_BASE + 32'h4, 4'hF, 32'h1, rd, er);
    check_value(fetch_enable, 1, "fetch_enable_o with register set");
    report_test("reset", start);
  endtask

  task automatic test_sram();
    int        start;
    sram_idx_t idx_list [SRAM_N];
    word_t     model [SRAM_N];
    word_t     wd;
    be_t       lanes;
    start = errors;
    // One distinct word index per slot
    for (int i = 0; i < SRAM_N; i++) begin
      idx_list[i] = sram_idx_t'(i * 8 + ($random(seed) & 7));
    end
    // Pass 0 full writes, pass 1 partial writes, pass 2 reads
    for (int pass = 0; pass < 3; pass++) begin
      for (int i = 0; i < SRAM_N; i++) begin
        wd    = $random(seed);
        lanes = (pass == 0) ? 4'hF : be_t'($random(seed));
        req   = 1'b1;
        we    = (pass < 2);
        addr  = `SOC_SRAM_BASE + {idx_list[i], 2'b00};
        be    = lanes;
        wdata = wd;
        if (pass < 2) model[i] = merge_bytes(model[i], wd, lanes);
        next_cycle();
        check_value(rvalid, 1, "SRAM rvalid one cycle after request");
        check_value(err, 0, "SRAM err");
        check_value(rdata, (pass < 2) ? '0 : model[i], "SRAM response data");
      end
    end
    req = 1'b0;
    we  = 1'b0;
    next_cycle();
    check_value(rvalid, 0, "SRAM rvalid after last response");
    report_test("sram", start);
  endtask

  task automatic test_errors();
    int    start;
    word_t rd;
    logic  er;
    start = errors;
    bus_access(1'b0, 32'h2000_0000, 4'hF, '0, rd, er);
    check_value(er, 1, "err_o on unmapped read");
    check_value(rd, `SOC_ERR_DATA, "rdata_o on unmapped read");
    bus_access(1'b1, 32'h2000_0004, 4'hF, 32'h1234_5678, rd, er);
    check_value(er, 1, "err_o on unmapped write");
    check_value(rd, `SOC_ERR_DATA, "rdata_o on unmapped write");
    bus_access(1'b0, `SOC_CTRL_BASE + 32'h8, 4'hF, '0, rd, er);
    check_value(er, 1, "err_o on undefined control offset read");
    check_value(rd, `SOC_ERR_DATA, "rdata_o on undefined control offset read");
    bus_access(1'b1, `SOC_CTRL_BASE + 32'h8, 4'hF, 32'hFFFF_FFFF, rd, er);
    check_value(er, 1, "err_o on undefined control offset write");
    check_value(rd, `SOC_ERR_DATA, "rdata_o on undefined control offset write");
    report_test("errors", start);
  endtask

  task automatic test_gpio();
    int        start;
    word_t     rd;
    logic      er;
    logic      seen;
    gpio_vec_t pins;
    start = errors;
    bus_access(1'b1, `SOC_GPIO_BASE, 4'hF, 32'hA5, rd, er);
    check_value(gpio_oe, 8'hA5, "gpio_out_en_o after direction write");
    bus_access(1'b1, `SOC_GPIO_BASE + 32'h4, 4'hF, 32'h3C, rd, er);
    check_value(gpio_out, 8'h3C, "gpio_o after output write");
    // Input path is two flops deep
    pins    = gpio_vec_t'($random(seed));
    gpio_in = pins;
    next_cycle();
    next_cycle();
    check_value(gpio_sync, pins, "gpio_in_sync_o two cycles after input change");
    bus_access(1'b0, `SOC_GPIO_BASE + 32'h8, 4'hF, '0, rd, er);
    check_value(rd, pins, "input register read");
    check_value(er, 0, "err_o on input register read");
    // Settle the pins low before arming pin 3
    gpio_in = '0;
    next_cycle();
    next_cycle();
    next_cycle();
    bus_access(1'b1, `SOC_GPIO_BASE + 32'hC, 4'hF, 32'h08, rd, er);
    check_value(irq[1], 0, "GPIO interrupt before edge");
    gpio_in[3] = 1'b1;
    wait_irq(1, seen);
    if (seen) begin
      bus_access(1'b0, `SOC_GPIO_BASE + 32'h10, 4'hF, '0, rd, er);
      check_value(rd, 32'h08, "pending register after edge");
      bus_access(1'b1, `SOC_GPIO_BASE + 32'h10, 4'hF, 32'h08, rd, er);
      check_value(irq[1], 0, "GPIO interrupt after pending clear");
    end
    report_test("gpio", start);
  endtask

  task automatic test_timer();
    int    start;
    word_t rd;
    logic  er;
    logic  seen;
    start = errors;
    bus_access(1'b1, `SOC_TIMER_BASE + 32'h8, 4'hF, 32'd10, rd, er);
    bus_access(1'b1, `SOC_TIMER_BASE, 4'hF, 32'h1, rd, er);
    wait_irq(0, seen);
    if (seen) begin
      next_cycle();
      check_value(irq[0], 0, "timer interrupt longer than one cycle");
    end
    bus_access(1'b0, `SOC_TIMER_BASE + 32'h4, 4'hF, '0, rd, er);
    check_value(er, 0, "err_o on timer count read");
    checks++;
    assert (rd <= 32'd10) else begin
      $display("FAIL at %0d ns: timer count %0d above compare value 10", $time, rd);
      errors++;
    end
    bus_access(1'b1, `SOC_TIMER_BASE, 4'hF, 32'h0, rd, er);
    report_test("timer", start);
  endtask

  // ------------------------------------------------
  // Sequence
  // ------------------------------------------------
  initial begin
    seed     = 50;
    errors   = 0;
    checks   = 0;
    tests    = 0;
    reset    = 1'b1;
    fetch_en = 1'b0;
    req      = 1'b0;
    we       = 1'b0;
    addr     = '0;
    be       = '0;
    wdata    = '0;
    gpio_in  = '0;
    repeat (8) @(posedge clk);
    #2;
    reset = 1'b0;

    test_reset_state();
    test_sram();
    test_errors();
    test_gpio();
    test_timer();

    $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== timer_unit.sv ====
// ------------------------------------------------
// Compare timer
// Free-running counter that wraps on compare match
// and pulses the interrupt for that cycle
// ------------------------------------------------
`include "soc_config.svh"

module timer_unit (
  input  logic   clk_i,
  input  logic   reset_i,
  soc_bus_if.sub bus,
  output logic   irq_o
);
  import soc_pkg::*;

  localparam int unsigned OffW = $clog2(`SOC_PERIPH_SIZE);
  localparam logic [OffW-1:0] OFF_CTRL  = 'h0;
  localparam logic [OffW-1:0] OFF_COUNT = 'h4;
  localparam logic [OffW-1:0] OFF_CMP   = 'h8;

  logic [OffW-1:0] offset;
  logic            wr;
  logic            en_q;
  word_t           count_q;
  word_t           cmp_q;
  logic            match;
  word_t           rd_word;
  logic            rvalid_q;
  word_t           rdata_q;

  assign offset = bus.addr[OffW-1:0];
  assign wr     = bus.req && bus.we;
  assign match  = en_q && (count_q == cmp_q);

  // ------------------------------------------------
  // Counter
  // ------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      en_q     <= 1'b0;
      count_q  <= '0;
      cmp_q    <= '0;
      rvalid_q <= 1'b0;
    end else begin
      if (wr && offset == OFF_CTRL) en_q  <= bus.wdata[0];
      if (wr && offset == OFF_CMP)  cmp_q <= bus.wdata;
      // Bus write to the count takes priority
      if (wr && offset == OFF_COUNT) begin
        count_q <= bus.wdata;
      end else if (match) begin
        count_q <= '0;
      end else if (en_q) begin
        count_q <= count_q + 1'b1;
      end
      rvalid_q <= bus.req;
    end
  end

  // Register read mux
  always_comb begin
    case (offset)
      OFF_CTRL:  rd_word = word_t'(en_q);
      OFF_COUNT: rd_word = count_q;
      OFF_CMP:   rd_word = cmp_q;
      default:   rd_word = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (bus.req) rdata_q <= bus.we ? '0 : rd_word;
  end

  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;
  assign bus.err    = 1'b0;

  assign irq_o = match;

endmodule
